/* project.f */
source/cpu_pkg.sv
source/exe_alu.sv
source/exe_mem_reg.sv
source/mem_access.sv
source/mem_wb_reg.sv
source/exe_backend_top.sv
tb/exe_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run from the project root so the test file is found
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exe_backend_tb -f project.f -o exe_backend_sim \
    && ./obj_dir/exe_backend_sim | tee /dev/stderr | grep -q -F '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* source/cpu_pkg.sv */
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////////////////

    // Data path and address width
    localparam int xlen = 32;

    // Register index width
    localparam int reg_addr_w = 5;

    // Data memory depth in words
    localparam int dmem_words = 64;

    // Word index width, taken from address bits 7:2
    // Upper address bits are ignored
    localparam int dmem_idx_w = $clog2(dmem_words);

    ////////////////////////////////////////////////////////////////////////
    // Reset values
    ////////////////////////////////////////////////////////////////////////

    // All-zero word for data, address and pc fields
    localparam logic [xlen-1:0] zero_word = '0;

    // Register 0, used while the pipe is empty
    localparam logic [reg_addr_w-1:0] nop_reg_addr = '0;

    ////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////

    // ALU operation
    // Shifts take the amount from the low 5 bits of operand b
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5,   // signed compare
        alu_sll = 3'd6,
        alu_srl = 3'd7
    } alu_op_e;

    // Memory operation carried down the pipe
    // mem_nop doubles as the reset value
    typedef enum logic [2:0] {
        mem_nop = 3'd0,
        mem_lw  = 3'd1,
        mem_lb  = 3'd2,   // sign extended
        mem_lbu = 3'd3,   // zero extended
        mem_sw  = 3'd4,
        mem_sb  = 3'd5
    } mem_op_e;

endpackage

/* source/exe_alu.sv */
module exe_alu (
    // Decoded instruction
    input  logic [cpu_pkg::xlen-1:0]       pc,
    input  cpu_pkg::alu_op_e               alu_op,
    input  logic [cpu_pkg::xlen-1:0]       op_a,
    input  logic [cpu_pkg::xlen-1:0]       op_b,
    input  logic [cpu_pkg::xlen-1:0]       imm,
    input  cpu_pkg::mem_op_e               mem_op,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_reg,
    input  logic                           we,

    // Toward the EXE/MEM register
    output logic [cpu_pkg::xlen-1:0]       exe_pc,
    output logic                           exe_we,
    output logic [cpu_pkg::reg_addr_w-1:0] exe_write_reg,
    output logic [cpu_pkg::xlen-1:0]       exe_write_data,
    output cpu_pkg::mem_op_e               exe_mem_op,
    output logic [cpu_pkg::xlen-1:0]       exe_mem_addr,
    output logic [cpu_pkg::xlen-1:0]       exe_mem_data
);

    ////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////

    // Shift amount from operand b
    logic [4:0] shamt;
    // Signed less-than flag
    logic       slt_bit;

    assign shamt   = op_b[4:0];
    assign slt_bit = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: exe_write_data = op_a + op_b;
            cpu_pkg::alu_sub: exe_write_data = op_a - op_b;
            cpu_pkg::alu_and: exe_write_data = op_a & op_b;
            cpu_pkg::alu_or:  exe_write_data = op_a | op_b;
            cpu_pkg::alu_xor: exe_write_data = op_a ^ op_b;
            // Result is 0 or 1
            cpu_pkg::alu_slt: begin
                exe_write_data = {{(cpu_pkg::xlen-1){1'b0}}, slt_bit};
            end
            // Logical shifts, zero fill
            cpu_pkg::alu_sll: exe_write_data = op_a << shamt;
            cpu_pkg::alu_srl: exe_write_data = op_a >> shamt;
            default:          exe_write_data = cpu_pkg::zero_word;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////////////////

    // Base plus offset, own adder so loads and stores
    // don't depend on the ALU opcode
    assign exe_mem_addr = op_a + imm;

    // Store data comes from the second operand
    assign exe_mem_data = op_b;

    // Control fields continue down the pipe
    assign exe_pc        = pc;
    assign exe_we        = we;
    assign exe_write_reg = write_reg;
    assign exe_mem_op    = mem_op;

endmodule

/* source/exe_backend_top.sv */
module exe_backend_top (
    input  logic                           clk,
    input  logic                           rst,

    // Decoded instruction, operands already read
    input  logic [cpu_pkg::xlen-1:0]       pc,
    input  cpu_pkg::alu_op_e               alu_op,
    input  logic [cpu_pkg::xlen-1:0]       op_a,
    input  logic [cpu_pkg::xlen-1:0]       op_b,
    input  logic [cpu_pkg::xlen-1:0]       imm,
    input  cpu_pkg::mem_op_e               mem_op,
    input  logic [cpu_pkg::reg_addr_w-1:0] write_reg,
    input  logic                           we,

    // Write-back port, two cycles after issue
    output logic [cpu_pkg::xlen-1:0]       wb_pc,
    output logic                           wb_we,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
    output logic [cpu_pkg::xlen-1:0]       wb_data,

    // Store record, one cycle after issue
    output logic [cpu_pkg::xlen-1:0]       last_store_addr,
    output logic [cpu_pkg::xlen-1:0]       last_store_data
);

    // Execute results
    logic [cpu_pkg::xlen-1:0]       exe_pc;
    logic                           exe_we;
    logic [cpu_pkg::reg_addr_w-1:0] exe_write_reg;
    logic [cpu_pkg::xlen-1:0]       exe_write_data;
    cpu_pkg::mem_op_e               exe_mem_op;
    logic [cpu_pkg::xlen-1:0]       exe_mem_addr;
    logic [cpu_pkg::xlen-1:0]       exe_mem_data;

    // MEM stage
    logic [cpu_pkg::xlen-1:0]       mem_pc;
    cpu_pkg::mem_op_e               mem_mem_op;
    logic [cpu_pkg::xlen-1:0]       mem_mem_addr;
    logic [cpu_pkg::xlen-1:0]       mem_mem_data;
    logic                           mem_we;
    logic [cpu_pkg::reg_addr_w-1:0] mem_write_reg;
    logic [cpu_pkg::xlen-1:0]       mem_write_data;

    // Memory access results
    logic                           acc_we;
    logic [cpu_pkg::reg_addr_w-1:0] acc_write_reg;
    logic [cpu_pkg::xlen-1:0]       acc_write_data;

    ////////////////////////////////////////////////////////////////////////
    // Stage chain
    ////////////////////////////////////////////////////////////////////////

    exe_alu u_exe_alu (.*);

    exe_mem_reg u_exe_mem_reg (.*);

    mem_access u_mem_access (.*);

    // pc bypasses the memory stage logic
    mem_wb_reg u_mem_wb_reg (.*);

endmodule

/* source/exe_mem_reg.sv */
module exe_mem_reg (
    input  logic                           clk,
    input  logic                           rst,

    // From execute
    input  logic [cpu_pkg::xlen-1:0]       exe_pc,
    input  logic                           exe_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] exe_write_reg,
    input  logic [cpu_pkg::xlen-1:0]       exe_write_data,
    input  cpu_pkg::mem_op_e               exe_mem_op,
    input  logic [cpu_pkg::xlen-1:0]       exe_mem_addr,
    input  logic [cpu_pkg::xlen-1:0]       exe_mem_data,

    // To memory access
    output logic [cpu_pkg::xlen-1:0]       mem_pc,
    output cpu_pkg::mem_op_e               mem_mem_op,
    output logic [cpu_pkg::xlen-1:0]       mem_mem_addr,
    output logic [cpu_pkg::xlen-1:0]       mem_mem_data,
    output logic                           mem_we,
    output logic [cpu_pkg::reg_addr_w-1:0] mem_write_reg,
    output logic [cpu_pkg::xlen-1:0]       mem_write_data,

    // Record of the store now in this stage
    output logic [cpu_pkg::xlen-1:0]       last_store_addr,
    output logic [cpu_pkg::xlen-1:0]       last_store_data
);

    // Loads every cycle, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_pc          <= cpu_pkg::zero_word;
            mem_mem_op      <= cpu_pkg::mem_nop;
            mem_mem_addr    <= cpu_pkg::zero_word;
            mem_mem_data    <= cpu_pkg::zero_word;
            mem_we          <= 1'b0;
            mem_write_reg   <= cpu_pkg::nop_reg_addr;
            mem_write_data  <= cpu_pkg::zero_word;
            last_store_addr <= cpu_pkg::zero_word;
            last_store_data <= cpu_pkg::zero_word;
        end else begin
            mem_pc         <= exe_pc;
            mem_mem_op     <= exe_mem_op;
            mem_mem_addr   <= exe_mem_addr;
            mem_mem_data   <= exe_mem_data;
            mem_we         <= exe_we;
            mem_write_reg  <= exe_write_reg;
            mem_write_data <= exe_write_data;

            // Word and byte stores both leave a record
            // Anything else clears it
            case (exe_mem_op)
                cpu_pkg::mem_sw, cpu_pkg::mem_sb: begin
                    last_store_addr <= exe_mem_addr;
                    last_store_data <= exe_mem_data;
                end
                default: begin
                    last_store_addr <= cpu_pkg::zero_word;
                    last_store_data <= cpu_pkg::zero_word;
                end
            endcase
        end
    end

    // A store never also writes a register in the same stage
    a_store_no_reg_write: assert property (
        @(posedge clk) disable iff (rst)
        (mem_mem_op == cpu_pkg::mem_sw || mem_mem_op == cpu_pkg::mem_sb) |-> !mem_we
    );

endmodule

/* source/mem_access.sv */
module mem_access (
    input  logic                           clk,

    // From the EXE/MEM register
    input  cpu_pkg::mem_op_e               mem_mem_op,
    input  logic [cpu_pkg::xlen-1:0]       mem_mem_addr,
    input  logic [cpu_pkg::xlen-1:0]       mem_mem_data,
    input  logic                           mem_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] mem_write_reg,
    input  logic [cpu_pkg::xlen-1:0]       mem_write_data,

    // Toward the MEM/WB register
    output logic                           acc_we,
    output logic [cpu_pkg::reg_addr_w-1:0] acc_write_reg,
    output logic [cpu_pkg::xlen-1:0]       acc_write_data
);

    ////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////

    logic [cpu_pkg::xlen-1:0] dmem [cpu_pkg::dmem_words];

    // Word index and byte lane from the effective address
    logic [cpu_pkg::dmem_idx_w-1:0] word_idx;
    logic [1:0]                     lane;
    // Bit offset of the lane, lane 0 is the low byte
    logic [4:0]                     lane_bit;

    assign word_idx = mem_mem_addr[cpu_pkg::dmem_idx_w+1:2];
    assign lane     = mem_mem_addr[1:0];
    assign lane_bit = {lane, 3'b000};

    // Memory starts cleared, no reset on the array
    initial begin
        for (int i = 0; i < cpu_pkg::dmem_words; i++) begin
            dmem[i] = cpu_pkg::zero_word;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Store path
    ////////////////////////////////////////////////////////////////////////

    // Array updates at the edge that ends the MEM cycle
    always_ff @(posedge clk) begin
        case (mem_mem_op)
            cpu_pkg::mem_sw: dmem[word_idx] <= mem_mem_data;
            // Only the addressed lane changes
            cpu_pkg::mem_sb: dmem[word_idx][lane_bit +: 8] <= mem_mem_data[7:0];
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Load path
    ////////////////////////////////////////////////////////////////////////

    logic [cpu_pkg::xlen-1:0] rd_word;
    logic [7:0]               rd_byte;

    // Combinational read, a store in the cycle before is already visible
    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[lane_bit +: 8];

    always_comb begin
        case (mem_mem_op)
            cpu_pkg::mem_lw:  acc_write_data = rd_word;
            cpu_pkg::mem_lb:  acc_write_data = {{(cpu_pkg::xlen-8){rd_byte[7]}}, rd_byte};
            cpu_pkg::mem_lbu: acc_write_data = {{(cpu_pkg::xlen-8){1'b0}}, rd_byte};
            // Non-loads keep the ALU result
            default:          acc_write_data = mem_write_data;
        endcase
    end

    // Register write control goes on unchanged
    assign acc_we        = mem_we;
    assign acc_write_reg = mem_write_reg;

    // Word accesses must be aligned
    a_word_aligned: assert property (
        @(posedge clk)
        (mem_mem_op == cpu_pkg::mem_lw || mem_mem_op == cpu_pkg::mem_sw)
            |-> (mem_mem_addr[1:0] == 2'b00)
    );

endmodule

/* source/mem_wb_reg.sv */
module mem_wb_reg (
    input  logic                           clk,
    input  logic                           rst,

    // From memory access
    input  logic [cpu_pkg::xlen-1:0]       mem_pc,
    input  logic                           acc_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] acc_write_reg,
    input  logic [cpu_pkg::xlen-1:0]       acc_write_data,

    // Write-back port
    output logic [cpu_pkg::xlen-1:0]       wb_pc,
    output logic                           wb_we,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_reg,
    output logic [cpu_pkg::xlen-1:0]       wb_data
);

    ////////////////////////////////////////////////////////////////////////
    // Final pipeline register
    ////////////////////////////////////////////////////////////////////////

    // Register 0 writes pass through as is
    // The register file drops them
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_pc   <= cpu_pkg::zero_word;
            wb_we   <= 1'b0;
            wb_reg  <= cpu_pkg::nop_reg_addr;
            wb_data <= cpu_pkg::zero_word;
        end else begin
            wb_pc   <= mem_pc;
            wb_we   <= acc_we;
            wb_reg  <= acc_write_reg;
            wb_data <= acc_write_data;
        end
    end

    // No write-back while the cleared MEM stage drains after reset
    a_no_wb_after_rst: assert property (
        @(posedge clk) $past(rst, 2) |-> !wb_we
    );

endmodule

/* tb/backend_input.txt */
# name pc alu_op op_a op_b imm mem_op write_reg we | wb_we wb_reg wb_data ls_addr ls_data
# alu_op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 srl | mem_op 0 nop 1 lw 2 lb 3 lbu 4 sw 5 sb
add_basic   00000100 0 00000005 00000007 00000000 0 1  1 1 1  0000000c 00000000 00000000
sub_wrap    00000104 1 00000003 00000005 00000000 0 2  1 1 2  fffffffe 00000000 00000000
and_mask    00000108 2 f0f01234 0ff0ff00 00000000 0 3  1 1 3  00f01200 00000000 00000000
or_mix      0000010c 3 a5000000 0000005a 00000000 0 4  1 1 4  a500005a 00000000 00000000
xor_flip    00000110 4 ffff0000 0f0f0f0f 00000000 0 5  1 1 5  f0f00f0f 00000000 00000000
slt_neg     00000114 5 ffffffff 00000001 00000000 0 6  1 1 6  00000001 00000000 00000000
slt_pos     00000118 5 00000002 fffffffe 00000000 0 7  1 1 7  00000000 00000000 00000000
sll_low5    0000011c 6 00000003 00000024 00000000 0 8  1 1 8  00000030 00000000 00000000
srl_zero    00000120 7 80000000 0000003f 00000000 0 9  1 1 9  00000001 00000000 00000000
sw_word     00000124 0 00000040 deadbeef 00000008 4 0  0 0 0  deadbf2f 00000048 deadbeef
lw_back     00000128 0 00000040 00000000 00000008 1 10 1 1 10 deadbeef 00000000 00000000
sb_lane2    0000012c 0 00000048 00000077 00000002 5 0  0 0 0  000000bf 0000004a 00000077
lw_after_sb 00000130 0 00000048 00000000 00000000 1 11 1 1 11 de77beef 00000000 00000000
sb_neg      00000134 0 00000050 000000f3 00000001 5 0  0 0 0  00000143 00000051 000000f3
lb_sign     00000138 0 00000050 00000000 00000001 2 12 1 1 12 fffffff3 00000000 00000000
lbu_zero    0000013c 0 00000050 00000000 00000001 3 13 1 1 13 000000f3 00000000 00000000
lbu_lane3   00000140 0 00000048 00000000 00000003 3 14 1 1 14 000000de 00000000 00000000
lb_pos      00000144 0 00000048 00000000 00000002 2 15 1 1 15 00000077 00000000 00000000
flow_a      00000148 0 00001000 00000234 00000000 0 16 1 1 16 00001234 00000000 00000000
flow_b      0000014c 1 00000010 00000011 00000000 0 17 1 1 17 ffffffff 00000000 00000000
flow_c      00000150 4 12345678 12345678 00000000 0 18 1 1 18 00000000 00000000 00000000
flow_d      00000154 3 00000000 0000beef 00000000 0 31 1 1 31 0000beef 00000000 00000000
sw_high     00000158 0 000001fc cafef00d 00000000 4 0  0 0 0  cafef209 000001fc cafef00d
lw_alias    0000015c 0 000000fc 00000000 00000000 1 19 1 1 19 cafef00d 00000000 00000000
sw_next     00000160 0 00000000 11111111 00000004 4 0  0 0 0  11111111 00000004 11111111
sb_lane0    00000164 0 00000004 000000aa 00000000 5 0  0 0 0  000000ae 00000004 000000aa
lw_word1    00000168 0 00000000 00000000 00000004 1 20 1 1 20 111111aa 00000000 00000000
add_x0      0000016c 0 00000001 00000001 00000000 0 0  1 1 0  00000002 00000000 00000000

/* tb/exe_backend_tb.sv */
module exe_backend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 4;

    logic                           clk;
    logic                           rst;
    logic [cpu_pkg::xlen-1:0]       pc;
    cpu_pkg::alu_op_e               alu_op;
    logic [cpu_pkg::xlen-1:0]       op_a;
    logic [cpu_pkg::xlen-1:0]       op_b;
    logic [cpu_pkg::xlen-1:0]       imm;
    cpu_pkg::mem_op_e               mem_op;
    logic [cpu_pkg::reg_addr_w-1:0] write_reg;
    logic                           we;
    logic [cpu_pkg::xlen-1:0]       wb_pc;
    logic                           wb_we;
    logic [cpu_pkg::reg_addr_w-1:0] wb_reg;
    logic [cpu_pkg::xlen-1:0]       wb_data;
    logic [cpu_pkg::xlen-1:0]       last_store_addr;
    logic [cpu_pkg::xlen-1:0]       last_store_data;

    // Test table, entry 0 is the reset check, file lines follow
    string                          t_name[$];
    logic [cpu_pkg::xlen-1:0]       t_pc[$];
    logic [2:0]                     t_alu[$];
    logic [cpu_pkg::xlen-1:0]       t_a[$];
    logic [cpu_pkg::xlen-1:0]       t_b[$];
    logic [cpu_pkg::xlen-1:0]       t_imm[$];
    logic [2:0]                     t_mem[$];
    logic [cpu_pkg::reg_addr_w-1:0] t_wr[$];
    logic                           t_we[$];
    logic                           x_we[$];
    logic [cpu_pkg::reg_addr_w-1:0] x_reg[$];
    logic [cpu_pkg::xlen-1:0]       x_data[$];
    logic [cpu_pkg::xlen-1:0]       x_ls_addr[$];
    logic [cpu_pkg::xlen-1:0]       x_ls_data[$];
    bit                             t_bad[$];

    int n_tests;
    int n_pass;
    int n_fail;
    bit loaded;
    bit read_ok;

    exe_backend_top DUT (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_test_file(output bit ok);
        int                       fd;
        int                       code;
        int                       ch;
        string                    tok;
        logic [cpu_pkg::xlen-1:0] f_pc;
        logic [cpu_pkg::xlen-1:0] f_a;
        logic [cpu_pkg::xlen-1:0] f_b;
        logic [cpu_pkg::xlen-1:0] f_imm;
        logic [cpu_pkg::xlen-1:0] f_data;
        logic [cpu_pkg::xlen-1:0] f_ls_a;
        logic [cpu_pkg::xlen-1:0] f_ls_d;
        int                       f_alu;
        int                       f_mem;
        int                       f_wr;
        int                       f_we;
        int                       f_xwe;
        int                       f_xreg;
        ok = 1'b1;
        // Reset entry, every output zero
        t_name.push_back("reset");
        t_pc.push_back('0);
        t_alu.push_back(3'd0);
        t_a.push_back('0);
        t_b.push_back('0);
        t_imm.push_back('0);
        t_mem.push_back(3'd0);
        t_wr.push_back('0);
        t_we.push_back(1'b0);
        x_we.push_back(1'b0);
        x_reg.push_back('0);
        x_data.push_back('0);
        x_ls_addr.push_back('0);
        x_ls_data.push_back('0);
        t_bad.push_back(1'b0);
        fd = $fopen("tb/backend_input.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
            return;
        end
        while (ok) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) break;
            // Comment line, skip to newline (10) or end of file
            if (tok.substr(0, 0) == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end else begin
                code = $fscanf(fd, "%h %d %h %h %h %d %d %d %d %d %h %h %h",
                               f_pc, f_alu, f_a, f_b, f_imm, f_mem, f_wr, f_we,
                               f_xwe, f_xreg, f_data, f_ls_a, f_ls_d);
                if (code != 13) begin
                    $display("Bad line in test file at test %s", tok);
                    ok = 1'b0;
                end else begin
                    t_name.push_back(tok);
                    t_pc.push_back(f_pc);
                    t_alu.push_back(f_alu[2:0]);
                    t_a.push_back(f_a);
                    t_b.push_back(f_b);
                    t_imm.push_back(f_imm);
                    t_mem.push_back(f_mem[2:0]);
                    t_wr.push_back(f_wr[4:0]);
                    t_we.push_back(f_we[0]);
                    x_we.push_back(f_xwe[0]);
                    x_reg.push_back(f_xreg[4:0]);
                    x_data.push_back(f_data);
                    x_ls_addr.push_back(f_ls_a);
                    x_ls_data.push_back(f_ls_d);
                    t_bad.push_back(1'b0);
                end
            end
        end
        $fclose(fd);
        n_tests = t_name.size() - 1;
        if (n_tests == 0) ok = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_idle();
        pc        = '0;
        alu_op    = cpu_pkg::alu_add;
        op_a      = '0;
        op_b      = '0;
        imm       = '0;
        mem_op    = cpu_pkg::mem_nop;
        write_reg = '0;
        we        = 1'b0;
    endtask

    task automatic drive_test(input int idx);
        pc        = t_pc[idx];
        alu_op    = cpu_pkg::alu_op_e'(t_alu[idx]);
        op_a      = t_a[idx];
        op_b      = t_b[idx];
        imm       = t_imm[idx];
        mem_op    = cpu_pkg::mem_op_e'(t_mem[idx]);
        write_reg = t_wr[idx];
        we        = t_we[idx];
    endtask

    task automatic compare_value(input int idx, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h, actual %h",
                     t_name[idx], what, expected, actual);
            t_bad[idx] = 1'b1;
        end
    endtask

    // Store record, one cycle after issue
    task automatic check_last_store(input int idx);
        compare_value(idx, "last_store_addr", x_ls_addr[idx], last_store_addr);
        compare_value(idx, "last_store_data", x_ls_data[idx], last_store_data);
    endtask

    // Write-back port, two cycles after issue
    task automatic check_write_back(input int idx);
        compare_value(idx, "wb_we", 32'(x_we[idx]), 32'(wb_we));
        compare_value(idx, "wb_reg", 32'(x_reg[idx]), 32'(wb_reg));
        compare_value(idx, "wb_data", x_data[idx], wb_data);
        compare_value(idx, "wb_pc", t_pc[idx], wb_pc);
    endtask

    task automatic report_test(input int idx);
        if (t_bad[idx]) begin
            n_fail++;
            $display("Test %0d %s failed", idx, t_name[idx]);
        end else begin
            n_pass++;
            $display("Test %0d %s passed", idx, t_name[idx]);
        end
    endtask

    task automatic run_tests();
        int wb_q[$];
        int prev_idx;
        int cur_idx;
        int done_idx;
        // Outputs checked at the falling edge, well clear of both updates
        for (int k = 0; k < reset_cycles; k++) begin
            @(posedge clk);
            #drive_delay;
            if (k == reset_cycles - 1) rst = 1'b0;
            @(negedge clk);
            check_last_store(0);
            check_write_back(0);
        end
        // Pipe still holds reset values for two more cycles
        wb_q.push_back(0);
        wb_q.push_back(0);
        prev_idx = 0;
        // One line per cycle, then two bubbles to drain
        for (int c = 0; c < n_tests + 2; c++) begin
            @(posedge clk);
            #drive_delay;
            if (c < n_tests) begin
                cur_idx = c + 1;
                drive_test(cur_idx);
            end else begin
                cur_idx = -1;
                drive_idle();
            end
            wb_q.push_back(cur_idx);
            @(negedge clk);
            if (prev_idx >= 0) check_last_store(prev_idx);
            done_idx = wb_q.pop_front();
            if (done_idx >= 0) begin
                check_write_back(done_idx);
                // Done at its last write-back check
                if (wb_q[0] != done_idx) report_test(done_idx);
            end
            prev_idx = cur_idx;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main flow and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst = 1'b1;
        drive_idle();
        n_pass = 0;
        n_fail = 0;
        read_test_file(read_ok);
        loaded = read_ok;
        if (!read_ok) begin
            $display("Could not read the tests from tb/backend_input.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            run_tests();
            $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
            if (n_fail == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

    // Run length is reset plus one cycle per line plus drain, ten cycles spare
    initial begin
        wait (loaded);
        #((n_tests + 10) * clk_period);
        $display("Timeout, the tests did not finish in %0d cycles", n_tests + 10);
        $display("** FAIL **");
        $finish;
    end

endmodule
